/* src/memBusPkg.sv */
// Memory bus package
// Shared widths for addresses, data words, request masks and phase tags
`default_nettype none

package memBusPkg;

  // One 36-bit memory word
  typedef logic [35:0] tWord;

  // Global word address
  // Bits 1:0 pick the word within a quad
  // The bits above them give the phase (quad number modulo phase count)
  // The rest is the quad number inside the bank
  typedef logic [19:0] tWordAddr;

  // Word address inside one phase's bank
  typedef logic [18:0] tBankAddr;

  // Word request mask
  // Bit k asks for the word at offset (start offset + k) mod 4
  // Bit 0 is the addressed word
  typedef logic [3:0] tRqMask;

  // Phase index, also the tag on returned words
  // Sized for at most two phases
  typedef logic [0:0] tPhaseIdx;

endpackage

`default_nettype wire

/* src/phaseCtlPkg.sv */
// Phase controller package
// Cycle FSM states and the fixed word timing of one phase
`default_nettype none

package phaseCtlPkg;

  // Phase cycle FSM
  typedef enum logic [2:0] {
    // No cycle running
    IDLE,
    // Start accepted, ackn goes out next
    ACK,
    // Word transfer, read or write
    DATA,
    // First hold cycle after a read word
    HOLD1,
    // Second hold cycle
    HOLD2,
    // Look for the next requested word in the quad
    NEXT
  } tPhaseState;

  // Cycles from an accepted start to ackn
  localparam int ACK_DELAY = 2;

  // Cycles between consecutive transferred words
  localparam int WORD_SPACING = 4;

endpackage

`default_nettype wire

/* src/phaseBus.sv */
// Request and response signals of one memory phase
// Driven by the dispatcher, served by the phase, drained by the collector
`default_nettype none

interface phaseBus;
  import memBusPkg::*;

  // Request side, from the dispatcher
  logic start;
  logic write;
  tBankAddr addr;
  tRqMask rqMask;
  tWord wrData;

  // Response side, from the phase controller
  logic busy;
  logic ackn;
  logic validIn;
  tWord rdData;

  // Dispatcher drives the request and watches busy
  modport dispatch (
    output start, write, addr, rqMask, wrData,
    input busy
  );

  // Phase controller serves the request
  modport phase (
    input start, write, addr, rqMask, wrData,
    output busy, ackn, validIn, rdData
  );

  // Collector only takes the read words
  modport collect (
    input validIn, rdData
  );

endinterface

`default_nettype wire

/* src/cycleDispatch.sv */
// Request dispatcher
// Steers each start to the phase owning the addressed quad, rejects starts to busy phases
`default_nettype none

module cycleDispatch #(
  parameter int NUM_PHASES = 2
) (
  input logic mbus,
  input logic reset,
  input logic start,
  input logic write,
  input memBusPkg::tWordAddr addr,
  input memBusPkg::tRqMask rqMask,
  input memBusPkg::tWord wrData,
  output logic reject,
  phaseBus.dispatch phases [NUM_PHASES]
);
  import memBusPkg::*;

  // Global quad number, address without the word offset
  logic [17:0] quad;
  // Quad number inside the selected bank
  logic [17:0] bankQuad;
  tPhaseIdx phaseSel;
  tBankAddr bankAddr;
  logic [NUM_PHASES-1:0] busyVec;

  // Quads are interleaved across phases
  assign quad = addr[19:2];
  assign phaseSel = tPhaseIdx'(quad % NUM_PHASES);
  assign bankQuad = 18'(quad / NUM_PHASES);
  // Keep the word offset, drop the phase bits
  assign bankAddr = tBankAddr'({bankQuad, addr[1:0]});

  for (genvar g = 0; g < NUM_PHASES; g++) begin : gPhase
    assign busyVec[g] = phases[g].busy;
    // Strobe only the addressed phase, and only when it is free
    assign phases[g].start = start && (phaseSel == tPhaseIdx'(g)) && !phases[g].busy;
    // Request fields go to every phase
    assign phases[g].write = write;
    assign phases[g].addr = bankAddr;
    assign phases[g].rqMask = rqMask;
    assign phases[g].wrData = wrData;
  end

  // Start to a busy phase is dropped
  // One-cycle reject pulse on the following cycle
  always_ff @(posedge mbus) begin
    if (reset) begin
      reject <= 1'b0;
    end else begin
      reject <= start && busyVec[phaseSel];
    end
  end

endmodule

`default_nettype wire

/* src/memPhase.sv */
// One memory phase controller
// Owns a bank of words and runs one read or write cycle at a time
`default_nettype none

module memPhase #(
  parameter int BANK_WORDS = 2048
) (
  input logic mbus,
  input logic reset,
  phaseBus.phase bus
);
  import memBusPkg::*;
  import phaseCtlPkg::*;

  localparam int BANK_BITS = $clog2(BANK_WORDS);

  // Core contents, zero at power up, kept across reset
  tWord bank [BANK_WORDS] = '{default: '0};

  tPhaseState state;
  // Word being transferred, offset wraps inside the quad
  logic [BANK_BITS-1:0] wordIdx;
  // Mask bits still to walk, bit 0 is the word after the current one
  logic [2:0] maskLeft;
  logic isWrite;
  tWord wrBuf;
  // Skip a word whose mask bit is clear
  logic skipWord;

  // Busy straight from the state so a start one cycle later is refused
  assign bus.busy = (state != IDLE);

  assign skipWord = (state == NEXT) && (maskLeft != 3'b000) && !maskLeft[0];

  // Cycle FSM
  always_ff @(posedge mbus) begin
    if (reset) begin
      state <= IDLE;
      maskLeft <= 3'b000;
      bus.ackn <= 1'b0;
      bus.validIn <= 1'b0;
    end else begin
      unique case (state)
        IDLE: begin
          if (bus.start) begin
            // Addressed word is always transferred first
            maskLeft <= bus.rqMask[3:1];
            state <= ACK;
          end
        end
        ACK: begin
          bus.ackn <= 1'b1;
          state <= DATA;
        end
        DATA: begin
          bus.ackn <= 1'b0;
          if (isWrite) begin
            // Single word stored at this edge, cycle done
            state <= IDLE;
          end else begin
            bus.validIn <= 1'b1;
            state <= HOLD1;
          end
        end
        HOLD1: begin
          bus.validIn <= 1'b0;
          state <= HOLD2;
        end
        HOLD2: begin
          state <= NEXT;
        end
        NEXT: begin
          if (maskLeft == 3'b000) begin
            state <= IDLE;
          end else begin
            maskLeft <= maskLeft >> 1;
            // Set bit, ack the next word
            // Clear bit costs one cycle here
            if (maskLeft[0]) begin
              bus.ackn <= 1'b1;
              state <= DATA;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, write data and bank access
  always_ff @(posedge mbus) begin
    if (state == IDLE && bus.start) begin
      wordIdx <= bus.addr[BANK_BITS-1:0];
      isWrite <= bus.write;
      wrBuf <= bus.wrData;
    end else if (state == DATA || skipWord) begin
      // Step to the next word, quad base stays
      wordIdx <= {wordIdx[BANK_BITS-1:2], wordIdx[1:0] + 2'd1};
    end
    if (state == DATA) begin
      if (isWrite) begin
        bank[wordIdx] <= wrBuf;
      end else begin
        bus.rdData <= bank[wordIdx];
      end
    end
  end

endmodule

`default_nettype wire

/* src/wordCollect.sv */
// Read word collector
// Merges all phases into one return stream with phase tag and odd parity
`default_nettype none

module wordCollect #(
  parameter int NUM_PHASES = 2
) (
  input logic mbus,
  input logic reset,
  phaseBus.collect phases [NUM_PHASES],
  output logic rdValid,
  output memBusPkg::tWord rdData,
  output logic rdParity,
  output memBusPkg::tPhaseIdx rdPhase
);
  import memBusPkg::*;

  logic [NUM_PHASES-1:0] validVec;
  tWord inData [NUM_PHASES];
  // One holding slot per phase
  tWord slotData [NUM_PHASES];
  logic [NUM_PHASES-1:0] slotFull;
  tPhaseIdx pick;
  logic anyFull;

  for (genvar g = 0; g < NUM_PHASES; g++) begin : gPhase
    assign validVec[g] = phases[g].validIn;
    assign inData[g] = phases[g].rdData;
  end

  // Lowest full slot wins
  always_comb begin
    pick = '0;
    for (int i = NUM_PHASES - 1; i >= 0; i--) begin
      if (slotFull[i]) begin
        pick = tPhaseIdx'(i);
      end
    end
  end

  assign anyFull = |slotFull;

  // Slot flags and output strobe
  always_ff @(posedge mbus) begin
    if (reset) begin
      slotFull <= '0;
      rdValid <= 1'b0;
    end else begin
      rdValid <= anyFull;
      for (int i = 0; i < NUM_PHASES; i++) begin
        // New word beats the drain, slot is always empty by then anyway
        if (validVec[i]) begin
          slotFull[i] <= 1'b1;
        end else if (anyFull && pick == tPhaseIdx'(i)) begin
          slotFull[i] <= 1'b0;
        end
      end
    end
  end

  // Word capture and output register
  always_ff @(posedge mbus) begin
    for (int i = 0; i < NUM_PHASES; i++) begin
      if (validVec[i]) begin
        slotData[i] <= inData[i];
      end
    end
    if (anyFull) begin
      rdData <= slotData[pick];
      // Odd weight over data plus parity
      rdParity <= ~^slotData[pick];
      rdPhase <= pick;
    end
  end

endmodule

`default_nettype wire

/* src/mb20Memory.sv */
// Interleaved core memory on the memory bus
// Dispatcher, NUM_PHASES phase controllers and the read word collector
`default_nettype none

module mb20Memory #(
  parameter int NUM_PHASES = 2,
  parameter int MEM_WORDS = 4096
) (
  input logic mbus,
  input logic reset,
  input logic start,
  input logic write,
  input memBusPkg::tWordAddr addr,
  input memBusPkg::tRqMask rqMask,
  input memBusPkg::tWord wrData,
  output logic reject,
  output logic [NUM_PHASES-1:0] ackn,
  output logic rdValid,
  output memBusPkg::tWord rdData,
  output logic rdParity,
  output memBusPkg::tPhaseIdx rdPhase
);

  // One bus per phase
  phaseBus bus [NUM_PHASES] ();

  cycleDispatch #(
    .NUM_PHASES(NUM_PHASES)
  ) i_cycleDispatch (
    .mbus(mbus),
    .reset(reset),
    .start(start),
    .write(write),
    .addr(addr),
    .rqMask(rqMask),
    .wrData(wrData),
    .reject(reject),
    .phases(bus)
  );

  for (genvar g = 0; g < NUM_PHASES; g++) begin : gPhase
    // Each bank holds its share of the interleaved words
    memPhase #(
      .BANK_WORDS(MEM_WORDS / NUM_PHASES)
    ) i_memPhase (
      .mbus(mbus),
      .reset(reset),
      .bus(bus[g])
    );

    assign ackn[g] = bus[g].ackn;
  end

  wordCollect #(
    .NUM_PHASES(NUM_PHASES)
  ) i_wordCollect (
    .mbus(mbus),
    .reset(reset),
    .phases(bus),
    .rdValid(rdValid),
    .rdData(rdData),
    .rdParity(rdParity),
    .rdPhase(rdPhase)
  );

endmodule

`default_nettype wire

/* verification/mb20Memory_sva.sv */
// Protocol checks on the memory top level
// Start acceptance, ackn timing, read word flow and collector output
`default_nettype none

module mb20MemorySva #(
  parameter int NUM_PHASES = 2
) (
  input logic mbus,
  input logic reset,
  input logic start,
  input memBusPkg::tWordAddr addr,
  input logic reject,
  input logic [NUM_PHASES-1:0] ackn,
  input logic [NUM_PHASES-1:0] busyVec,
  input logic [NUM_PHASES-1:0] validIn,
  input logic rdValid
);
  import memBusPkg::*;

  tPhaseIdx startPhase;
  logic startAccepted;
  // Read words taken in by the collector and not yet returned
  int pending;

  // Phase is the quad number modulo the phase count
  assign startPhase = tPhaseIdx'(addr[19:2] % NUM_PHASES);
  assign startAccepted = start && !busyVec[startPhase];

  always_ff @(posedge mbus) begin
    if (reset) begin
      pending <= 0;
    end else begin
      pending <= pending + $countones(validIn) - int'(rdValid);
    end
  end

  // Accepted start gets its ackn two cycles later
  ackAfterStart: assert property (@(posedge mbus) disable iff (reset)
    $past(startAccepted, 2) |-> ackn[$past(startPhase, 2)])
    else $error("ackn missing two cycles after an accepted start");

  for (genvar g = 0; g < NUM_PHASES; g++) begin : gPhase
    // Read word comes one cycle after its ackn
    validAfterAckn: assert property (@(posedge mbus) disable iff (reset)
      validIn[g] |-> $past(ackn[g]))
      else $error("validIn without ackn one cycle before");

    // Ackn of a cycle started from idle never comes with a reject of that start
    noRejectOnAccept: assert property (@(posedge mbus) disable iff (reset)
      ackn[g] && !$past(busyVec[g], 2) |-> !$past(reject))
      else $error("reject raised for a start that was acknowledged");
  end

  // Output strobe needs a read word held in the collector
  validNeedsSlot: assert property (@(posedge mbus) disable iff (reset)
    rdValid |-> pending > 0)
    else $error("rdValid high with no slot full");

endmodule

`default_nettype wire

/* verification/mb20MemoryTb.sv */
// Testbench for the interleaved core memory
// Random reads and writes checked against a word-level model
`default_nettype none

module mb20MemoryTb;
  import memBusPkg::*;

  localparam int NUM_PHASES = 2;
  localparam int MEM_WORDS = 4096;
  localparam int NUM_OPS = 300;
  // Full mask read, ack plus three spaced words, holds and return to idle
  localparam int MAX_CYCLE_LEN = 18;
  localparam int CYCLE_LIMIT = 20 * NUM_OPS * MAX_CYCLE_LEN;

  logic mbus = 1'b0;
  logic reset;
  logic start;
  logic write;
  tWordAddr addr;
  tRqMask rqMask;
  tWord wrData;
  logic reject;
  logic [NUM_PHASES-1:0] ackn;
  logic rdValid;
  tWord rdData;
  logic rdParity;
  tPhaseIdx rdPhase;

  // Reference model state
  tWord memModel [MEM_WORDS];
  int busyLeft [NUM_PHASES];
  bit readCycle [NUM_PHASES];
  tWord expWords [NUM_PHASES][$];
  int expAckn [NUM_PHASES][$];
  int tick = 0;
  int cycleCount = 0;
  bit rejectDue = 1'b0;
  int rejectCount = 0;
  int overlapCount = 0;

  mb20Memory #(
    .NUM_PHASES(NUM_PHASES),
    .MEM_WORDS(MEM_WORDS)
  ) i_mb20Memory (.*);

  bind mb20Memory mb20MemorySva #(
    .NUM_PHASES(NUM_PHASES)
  ) i_mb20MemorySva (
    .mbus(mbus),
    .reset(reset),
    .start(start),
    .addr(addr),
    .reject(reject),
    .ackn(ackn),
    .busyVec(i_cycleDispatch.busyVec),
    .validIn(i_wordCollect.validVec),
    .rdValid(rdValid)
  );

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  // Queue the ackn ticks and read words of an accepted start
  task automatic acceptStart(input int p);
    int idx;
    int cur;
    int last;
    idx = int'(addr);
    cur = tick + 2;
    last = cur;
    expAckn[p].push_back(cur);
    if (write) begin
      memModel[idx] = wrData;
      busyLeft[p] = 2;
    end else begin
      expWords[p].push_back(memModel[idx]);
      for (int k = 1; k < 4; k++) begin
        if (rqMask[k]) begin
          cur = cur + 4;
          last = cur;
          expAckn[p].push_back(cur);
          // Offset wraps inside the quad
          expWords[p].push_back(memModel[(idx & ~3) + ((idx + k) & 3)]);
        end else begin
          cur = cur + 1;
        end
      end
      // Two holds and the step back to idle after the last word
      busyLeft[p] = last + 3 - tick;
    end
    readCycle[p] = !write;
  endtask

  // One returned word against the phase's expected queue
  task automatic checkWord();
    int ph;
    tWord expW;
    ph = int'(rdPhase);
    assert (expWords[ph].size() > 0)
      else failRun($sformatf("Read word returned on phase %0d with none expected", ph));
    expW = expWords[ph].pop_front();
    assert (rdData == expW)
      else failRun($sformatf("ERROR rdData: got 0x%h expected 0x%h", rdData, expW));
    // Odd weight over 36 data bits plus parity
    assert (^{rdParity, rdData} == 1'b1)
      else failRun($sformatf("ERROR rdParity: got 0x%h with rdData 0x%h, weight not odd",
        rdParity, rdData));
  endtask

  // Values seen here are the ones sampled at the next rising edge
  task automatic checkTick();
    int p;
    bit expA;
    bit busyNow [NUM_PHASES];
    tick++;
    assert (reject == rejectDue)
      else failRun($sformatf("ERROR reject: got 0x%h expected 0x%h", reject, rejectDue));
    for (int q = 0; q < NUM_PHASES; q++) begin
      expA = (expAckn[q].size() > 0) && (expAckn[q][0] == tick);
      if (expA) begin
        void'(expAckn[q].pop_front());
      end
      assert (ackn[q] == expA)
        else failRun($sformatf("ERROR ackn[%0d]: got 0x%h expected 0x%h", q, ackn[q], expA));
      busyNow[q] = busyLeft[q] > 0;
      if (busyNow[q]) begin
        busyLeft[q] = busyLeft[q] - 1;
      end
    end
    if (rdValid) begin
      checkWord();
    end
    rejectDue = 1'b0;
    if (start) begin
      // Quad number modulo phase count
      p = int'(addr[19:2]) % NUM_PHASES;
      if (busyNow[p]) begin
        rejectDue = 1'b1;
        rejectCount++;
      end else begin
        for (int q = 0; q < NUM_PHASES; q++) begin
          if (q != p && !write && readCycle[q] && busyNow[q]) begin
            overlapCount++;
          end
        end
        acceptStart(p);
      end
    end
  endtask

  function automatic bit modelIdle();
    bit idle;
    idle = 1'b1;
    for (int q = 0; q < NUM_PHASES; q++) begin
      if (busyLeft[q] > 0 || expWords[q].size() > 0 || expAckn[q].size() > 0) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic driveRandomStart();
    @(posedge mbus);
    #10;
    start = 1'b1;
    write = ($urandom_range(99, 0) < 40);
    // Mostly a small window so writes get read back, now and then anywhere
    if ($urandom_range(9, 0) == 0) begin
      addr = tWordAddr'($urandom_range(MEM_WORDS - 1, 0));
    end else begin
      addr = tWordAddr'($urandom_range(31, 0));
    end
    // Bit 0 is the addressed word
    rqMask = tRqMask'($urandom_range(15, 0)) | 4'b0001;
    wrData = tWord'({$urandom, $urandom});
  endtask

  task automatic driveIdle();
    @(posedge mbus);
    #10;
    start = 1'b0;
  endtask

  initial begin
    forever #50 mbus = ~mbus;
  end

  always @(negedge mbus) begin
    if (!reset) begin
      checkTick();
    end
  end

  // Watchdog
  always @(posedge mbus) begin
    cycleCount++;
    if (cycleCount > CYCLE_LIMIT) begin
      failRun("Timed out before the memory went idle");
    end
  end

  initial begin
    int gap;
    void'($urandom(84994));
    reset = 1'b1;
    start = 1'b0;
    write = 1'b0;
    addr = '0;
    rqMask = '0;
    wrData = '0;
    // Core starts out zero
    for (int i = 0; i < MEM_WORDS; i++) begin
      memModel[i] = '0;
    end
    for (int q = 0; q < NUM_PHASES; q++) begin
      busyLeft[q] = 0;
      readCycle[q] = 1'b0;
    end
    repeat (10) @(posedge mbus);
    #10;
    reset = 1'b0;
    // Short gaps give rejects and overlapping reads
    for (int n = 0; n < NUM_OPS; n++) begin
      driveRandomStart();
      gap = $urandom_range(6, 0);
      repeat (gap) driveIdle();
    end
    driveIdle();
    while (!modelIdle()) begin
      @(posedge mbus);
    end
    // Catch stray words after the drain
    repeat (8) @(posedge mbus);
    assert (rejectCount > 0) else failRun("No start ever hit a busy phase");
    assert (overlapCount > 0) else failRun("Reads on the two phases never overlapped");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
src/memBusPkg.sv
src/phaseCtlPkg.sv
src/phaseBus.sv
src/cycleDispatch.sv
src/memPhase.sv
src/wordCollect.sv
src/mb20Memory.sv
verification/mb20Memory_sva.sv
verification/mb20MemoryTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the memory testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mb20MemoryTb -f project.f -o mb20Sim \
  && ./obj_dir/mb20Sim > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
